// ==== video_crop.f ====
hw/video_crop_pkg.sv
hw/raster_timing.sv
hw/blank_gen.sv
hw/crop_keys.sv
hw/screen_info.sv
hw/video_crop_top.sv
dv/tb_clock_gen.sv
dv/video_crop_properties.sv
dv/tb_video_crop.sv

// ==== run.sh ====
#!/bin/sh
# build and run the crop block testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_video_crop -f video_crop.f -o sim_video_crop
./obj_dir/sim_video_crop > sim.log 2>&1 || true
cat sim.log
if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
else
	exit 1
fi

// ==== dv/tb_video_crop.sv ====
// random rasters and key events from an lcg (seed 50); sizes are checked from the third frame of a run
`timescale 1ns/10ps
`default_nettype none

module tb_video_crop import video_crop_pkg::*; ();

	logic          clk_sys;
	logic          reset;
	video_sync_t   sync;
	logic [1:0]    res;
	kbd_event_t    kbd;
	logic          preset_load;
	crop_margins_t preset;
	logic          hde;
	logic          vde;
	screen_info_t  info;

	int unsigned   rng_state = 50;
	int            mismatches = 0;
	int            failures = 0;
	int            line_len, hsw, hbe, hbs; // raster geometry of the current run
	int            frame_h, vsw, vbe, vbs;
	int            frame_idx;
	int            keys_left;
	int            line_hde;
	int            vis_lines, exp_lines;
	int            old_hsize; // sizes of the previous run, -1 before the first
	int            old_vsize;
	logic          line_vis;
	logic [1:0]    run_res;
	crop_margins_t m_margins; // reference margins
	logic          m_alt;
	logic          m_level;
	logic          m_svbl, m_fvbl;
	screen_info_t  m_last;    // expected fields of the previous snapshot
	logic          m_last_ok;
	logic [6:0]    m_flg;

	tb_clock_gen clock_gen_inst (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	video_crop_top video_crop_top_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.sync        (sync),
		.res         (res),
		.kbd         (kbd),
		.preset_load (preset_load),
		.preset      (preset),
		.hde         (hde),
		.vde         (vde),
		.info        (info)
	);

	function automatic int unsigned next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return (rng_state >> 16) & 32'h7fff;
	endfunction

	function automatic int rand_range(int lo, int hi);
		int r;
		r = int'(next_rand());
		return lo + r % (hi - lo + 1);
	endfunction

	task automatic report_mismatch(string name, int got, int exp);
		$display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
		mismatches++;
	endtask

	task automatic send_key(logic [1:0] kind, logic [7:0] code, logic toggle);
		logic lvl;
		lvl = toggle ? ~m_level : m_level;
		kbd <= {lvl, kind, code};
		m_level = lvl;
	endtask

	// picks one event and applies the step rules to the reference margins
	task automatic send_random_event();
		int            r;
		coord_t        cur;
		logic          up;
		crop_margins_t p;
		r = rand_range(0, 15);
		if (r == 0) begin
			p.hbl_l = coord_t'(rand_range(0, 8));
			p.hbl_r = coord_t'(rand_range(0, 8));
			p.vbl_t = coord_t'(rand_range(0, 3));
			p.vbl_b = coord_t'(rand_range(0, 3));
			preset      <= p;
			preset_load <= 1'b1;
			send_key(KIND_KEY, KEY_UP, 1'b1); // same cycle key loses
			m_margins = p;
		end else if (r == 1) begin
			send_key(2'(rand_range(0, 2)), KEY_UP, 1'b1); // wrong kind
		end else if (r == 2) begin
			send_key(KIND_KEY, KEY_LEFT, 1'b0); // level unchanged
		end else if (r == 3) begin
			send_key(KIND_KEY, KEY_RESET, 1'b1);
			m_margins = '0;
		end else if (r == 4) begin
			if (m_alt)
				send_key(KIND_KEY, rand_range(0, 1) == 0 ? KEY_ALT_UP0 : KEY_ALT_UP1, 1'b1);
			else
				send_key(KIND_KEY, rand_range(0, 1) == 0 ? KEY_ALT_DN0 : KEY_ALT_DN1, 1'b1);
			m_alt = ~m_alt;
		end else if (rand_range(0, 1) == 0) begin
			cur = m_alt ? m_margins.vbl_b : m_margins.vbl_t;
			up  = (cur < V_STEP) || (cur <= 12'd2 && rand_range(0, 1) == 1);
			send_key(KIND_KEY, up ? KEY_UP : KEY_DOWN, 1'b1);
			cur = up ? cur + V_STEP : cur - V_STEP;
			if (m_alt)
				m_margins.vbl_b = cur;
			else
				m_margins.vbl_t = cur;
		end else begin
			cur = m_alt ? m_margins.hbl_r : m_margins.hbl_l;
			up  = (cur < H_STEP) || (cur <= 12'd4 && rand_range(0, 1) == 1);
			send_key(KIND_KEY, up ? KEY_LEFT : KEY_RIGHT, 1'b1);
			cur = up ? cur + H_STEP : cur - H_STEP;
			if (m_alt)
				m_margins.hbl_r = cur;
			else
				m_margins.hbl_l = cur;
		end
	endtask

	// crop window clipped by the forced border, in hcnt units
	function automatic int expected_width();
		int a, b, hm, lo, hi;
		a  = hbe - hsw + int'(m_margins.hbl_l) - 2;
		b  = hbs - hsw + int'(m_margins.hbl_r) - 2;
		hm = line_len - hsw;
		lo = (a + 1 > 9) ? a + 1 : 9;
		hi = (b < hm - 8) ? b : hm - 8;
		return (hi >= lo) ? hi - lo + 1 : 0;
	endfunction

	task automatic check_snapshot();
		int   exp_h;
		int   exp_v;
		logic changed;
		// sizes of a new run reach the record one frame later
		exp_h = (frame_idx == 0) ? old_hsize : hbs - hbe;
		exp_v = (frame_idx == 0) ? old_vsize : vbs - vbe;
		if (info.margins.hbl_l != m_margins.hbl_l)
			report_mismatch("info.margins.hbl_l", int'(info.margins.hbl_l), int'(m_margins.hbl_l));
		if (info.margins.hbl_r != m_margins.hbl_r)
			report_mismatch("info.margins.hbl_r", int'(info.margins.hbl_r), int'(m_margins.hbl_r));
		if (info.margins.vbl_t != m_margins.vbl_t)
			report_mismatch("info.margins.vbl_t", int'(info.margins.vbl_t), int'(m_margins.vbl_t));
		if (info.margins.vbl_b != m_margins.vbl_b)
			report_mismatch("info.margins.vbl_b", int'(info.margins.vbl_b), int'(m_margins.vbl_b));
		if (info.res != run_res)
			report_mismatch("info.res", int'(info.res), int'(run_res));
		if (frame_idx >= 2 && int'(info.hsize) != hbs - hbe)
			report_mismatch("info.hsize", int'(info.hsize), hbs - hbe);
		if (frame_idx >= 2 && int'(info.vsize) != vbs - vbe)
			report_mismatch("info.vsize", int'(info.vsize), vbs - vbe);
		changed = (m_last.res != run_res) || (int'(m_last.hsize) != exp_h) ||
			(int'(m_last.vsize) != exp_v);
		if (m_last_ok && exp_h >= 0) begin
			if (changed)
				m_flg = m_flg + 7'd1; // wraps at 128
			if (info.flg != m_flg)
				report_mismatch("info.flg", int'(info.flg), int'(m_flg));
		end else begin
			m_flg = info.flg; // sizes before the first full frame are unknown
		end
		m_last.res   = run_res;
		m_last.hsize = coord_t'(exp_h);
		m_last.vsize = coord_t'(exp_v);
		m_last_ok    = (exp_h >= 0);
	endtask

	task automatic run_cycle(int x, int y);
		video_sync_t s;
		s.hs     = (x >= hsw);
		s.vs     = (y >= vsw);
		s.hblank = (x < hbe) || (x >= hbs);
		s.vblank = (y < vbe) || (y >= vbs);
		@(posedge clk_sys);
		sync        <= s;
		res         <= run_res;
		preset_load <= 1'b0;
		if (x == 5 && keys_left > 0) begin
			send_random_event();
			keys_left--;
		end
		@(negedge clk_sys);
		if (hde)
			line_hde++;
		if (hde && vde)
			line_vis = 1'b1;
		if (x == 2 && y == vbe)
			check_snapshot(); // record written after the picture start cycle
	endtask

	// vertical flags step once per line at the window opening
	task automatic finish_line(int y);
		int v, width;
		v = (y < vsw) ? 0 : y - vsw + 1;
		if (v == vbe - vsw + int'(m_margins.vbl_t) - 1)
			m_svbl = 1'b0;
		if (v == vbs - vsw + int'(m_margins.vbl_b) - 1)
			m_svbl = 1'b1;
		if (v == 1)
			m_fvbl = 1'b0;
		if (v == frame_h - vsw - 3)
			m_fvbl = 1'b1;
		width = expected_width();
		if (frame_idx >= 2 && line_hde != width)
			report_mismatch("hde width", line_hde, width);
		if (!m_svbl && !m_fvbl && width > 0)
			exp_lines++;
		if (line_vis)
			vis_lines++;
	endtask

	task automatic run_all();
		for (int run = 0; run < 6; run++) begin
			old_hsize = (run == 0) ? -1 : hbs - hbe;
			old_vsize = (run == 0) ? -1 : vbs - vbe;
			line_len  = rand_range(120, 200);
			hsw       = rand_range(4, 10);
			hbe       = hsw + rand_range(6, 16);
			hbs       = line_len - rand_range(8, 24);
			frame_h   = rand_range(30, 50);
			vsw       = rand_range(1, 3);
			vbe       = vsw + rand_range(3, 6);
			vbs       = frame_h - rand_range(5, 8);
			run_res   = 2'(rand_range(0, 3));
			for (int f = 0; f < 4; f++) begin
				frame_idx = f;
				keys_left = rand_range(0, 3);
				vis_lines = 0;
				exp_lines = 0;
				for (int y = 0; y < frame_h; y++) begin
					line_hde = 0;
					line_vis = 1'b0;
					for (int x = 0; x < line_len; x++)
						run_cycle(x, y);
					finish_line(y);
				end
				if (f >= 2 && vis_lines != exp_lines)
					report_mismatch("visible lines", vis_lines, exp_lines);
			end
		end
	endtask

	initial begin
		int wait_cycles;
		sync        <= 4'b1100; // hs and vs idle high, no blank
		res         <= 2'd0;
		kbd         <= '0;
		preset_load <= 1'b0;
		preset      <= '0;
		m_margins   = '0;
		m_alt       = 1'b0;
		m_level     = 1'b0;
		m_svbl      = 1'b0;
		m_fvbl      = 1'b0;
		m_last      = '0;
		m_last_ok   = 1'b0;
		m_flg       = '0;
		run_res     = 2'd0;
		wait_cycles = 0;
		while (reset !== 1'b0 && wait_cycles < 100) begin
			@(negedge clk_sys);
			wait_cycles++;
		end
		if (reset !== 1'b0) begin
			$display("reset was not released within 100 cycles");
			failures++;
		end else begin
			run_all();
		end
		$display("errors: mismatches=%0d other=%0d", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/video_crop_properties.sv ====
// bound to video_crop_top; relies on the internal vblank_end pulse of the top level
`timescale 1ns/10ps
`default_nettype none

module video_crop_properties import video_crop_pkg::*; (
	input logic         clk_sys,
	input logic         reset,
	input video_sync_t  sync,
	input logic         hde,
	input logic         vde,
	input screen_info_t info,
	input logic         vblank_end
);

	enables_low_in_reset: assert property (@(posedge clk_sys) reset |-> (!hde && !vde))
		else $error("display enable high while reset is active");

	// hde is one register behind hs
	hde_low_after_hs: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(sync.hs) |-> !hde)
		else $error("hde high one cycle after hs was low");

	flg_moves_on_snapshot: assert property (@(posedge clk_sys) disable iff (reset)
		$changed(info.flg) |-> $past(vblank_end))
		else $error("info.flg changed outside the cycle after vblank_end");

endmodule

bind video_crop_top video_crop_properties video_crop_properties_inst (
	.clk_sys    (clk_sys),
	.reset      (reset),
	.sync       (sync),
	.hde        (hde),
	.vde        (vde),
	.info       (info),
	.vblank_end (vblank_end)
);

`default_nettype wire

// ==== dv/tb_clock_gen.sv ====
// free running 10 ns clock, reset held high for the first 16 rising edges
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (16) @(posedge clk_sys);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// ==== hw/video_crop_top.sv ====
// single clock block on clk_sys, chipset sync must already be synchronous to it
`timescale 1ns/10ps
`default_nettype none

module video_crop_top import video_crop_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  video_sync_t   sync,
	input  logic [1:0]    res,
	input  kbd_event_t    kbd,
	input  logic          preset_load,
	input  crop_margins_t preset,
	output logic          hde,
	output logic          vde,
	output screen_info_t  info
);

	raster_pos_t   pos;
	raster_geom_t  geom;
	coord_t        hsize;
	coord_t        vsize;
	logic          vblank_end; // start of picture pulse
	crop_margins_t margins;

	raster_timing raster_timing_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.sync       (sync),
		.pos        (pos),
		.geom       (geom),
		.hsize      (hsize),
		.vsize      (vsize),
		.vblank_end (vblank_end)
	);

	blank_gen blank_gen_inst (
		.clk_sys (clk_sys),
		.reset   (reset),
		.hs      (sync.hs),
		.pos     (pos),
		.geom    (geom),
		.margins (margins),
		.hde     (hde),
		.vde     (vde)
	);

	crop_keys crop_keys_inst (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.kbd         (kbd),
		.preset_load (preset_load),
		.preset      (preset),
		.margins     (margins)
	);

	screen_info screen_info_inst (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.vblank_end (vblank_end),
		.margins    (margins),
		.hsize      (hsize),
		.vsize      (vsize),
		.res        (res),
		.info       (info)
	);

endmodule

`default_nettype wire

// ==== hw/screen_info.sv ====
// record is taken once per picture start, so a host sees values one frame old at most
`timescale 1ns/10ps
`default_nettype none

module screen_info import video_crop_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          vblank_end,
	input  crop_margins_t margins,
	input  coord_t        hsize,
	input  coord_t        vsize,
	input  logic [1:0]    res,
	output screen_info_t  info
);

	logic changed;

	// compared against the last snapshot, not the live values
	assign changed = (info.res != res) || (info.hsize != hsize) || (info.vsize != vsize);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			info <= '0;
		end else if (vblank_end) begin
			info.margins <= margins;
			info.hsize   <= hsize;
			info.vsize   <= vsize;
			info.res     <= res;
			if (changed)
				info.flg <= info.flg + 7'd1; // wraps at 128
		end
	end

endmodule

`default_nettype wire

// ==== hw/crop_keys.sv ====
// steps wrap modulo 4096 and a held alt survives until its release code is seen
`timescale 1ns/10ps
`default_nettype none

module crop_keys import video_crop_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  kbd_event_t    kbd,
	input  logic          preset_load,
	input  crop_margins_t preset,
	output crop_margins_t margins
);

	logic level_d;
	logic alt;     // alt key held
	logic new_key;

	assign new_key = (level_d ^ kbd.level) && (kbd.kind == KIND_KEY);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			level_d <= 1'b0;
			alt     <= 1'b0;
			margins <= '0;
		end else begin
			level_d <= kbd.level;

			if (new_key) begin
				case (kbd.code)
					KEY_RESET: margins <= '0;
					KEY_UP: begin
						if (alt)
							margins.vbl_b <= margins.vbl_b + V_STEP;
						else
							margins.vbl_t <= margins.vbl_t + V_STEP;
					end
					KEY_DOWN: begin
						if (alt)
							margins.vbl_b <= margins.vbl_b - V_STEP;
						else
							margins.vbl_t <= margins.vbl_t - V_STEP;
					end
					KEY_LEFT: begin
						if (alt)
							margins.hbl_r <= margins.hbl_r + H_STEP;
						else
							margins.hbl_l <= margins.hbl_l + H_STEP;
					end
					KEY_RIGHT: begin
						if (alt)
							margins.hbl_r <= margins.hbl_r - H_STEP;
						else
							margins.hbl_l <= margins.hbl_l - H_STEP;
					end
					KEY_ALT_DN0, KEY_ALT_DN1: alt <= 1'b1;
					KEY_ALT_UP0, KEY_ALT_UP1: alt <= 1'b0;
					default: ; // other keys ignored
				endcase
			end

			if (preset_load)
				margins <= preset; // host preset overrides a same cycle key
		end
	end

endmodule

`default_nettype wire

// ==== hw/blank_gen.sv ====
// margins are not range checked, a margin past the blank edge wraps and may hide the window
`timescale 1ns/10ps
`default_nettype none

module blank_gen import video_crop_pkg::*; (
	input  logic          clk_sys,
	input  logic          reset,
	input  logic          hs,
	input  raster_pos_t   pos,
	input  raster_geom_t  geom,
	input  crop_margins_t margins,
	output logic          hde,
	output logic          vde
);

	logic shbl;     // crop blank, horizontal
	logic fhbl;     // forced border, horizontal
	logic svbl;
	logic fvbl;
	logic svbl_nxt;
	logic fvbl_nxt;
	logic hbl;
	logic hbl_d;
	logic hbl_edge; // line start of the cropped video

	assign hbl      = shbl | fhbl | ~hs;
	assign hbl_edge = hbl_d & ~hbl;

	// vertical flags move only when a cropped line opens
	always_comb begin
		svbl_nxt = svbl;
		fvbl_nxt = fvbl;
		if (hbl_edge) begin
			if (pos.vcnt == geom.vend + margins.vbl_t - V_PIPE)
				svbl_nxt = 1'b0;
			if (pos.vcnt == geom.vsta + margins.vbl_b - V_PIPE)
				svbl_nxt = 1'b1;
			if (pos.vcnt == V_FORCE_TOP)
				fvbl_nxt = 1'b0;
			if (pos.vcnt == geom.vmax - V_FORCE_BOT)
				fvbl_nxt = 1'b1;
		end
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			shbl  <= 1'b0;
			fhbl  <= 1'b0;
			svbl  <= 1'b0;
			fvbl  <= 1'b0;
			hbl_d <= 1'b0;
			hde   <= 1'b0;
			vde   <= 1'b0;
		end else begin
			if (pos.hcnt == geom.hend + margins.hbl_l - H_PIPE)
				shbl <= 1'b0;
			if (pos.hcnt == geom.hsta + margins.hbl_r - H_PIPE)
				shbl <= 1'b1;

			if (pos.hcnt == H_FORCE)
				fhbl <= 1'b0; // border just inside sync
			if (pos.hcnt == geom.hmax - H_FORCE)
				fhbl <= 1'b1;

			svbl  <= svbl_nxt;
			fvbl  <= fvbl_nxt;
			hbl_d <= hbl;
			hde   <= ~hbl;
			vde   <= ~(svbl_nxt | fvbl_nxt); // tracks the flags, low in reset
		end
	end

endmodule

`default_nettype wire

// ==== hw/raster_timing.sv ====
// geometry is learned from the previous edges, so values settle only after one full frame
`timescale 1ns/10ps
`default_nettype none

module raster_timing import video_crop_pkg::*; (
	input  logic         clk_sys,
	input  logic         reset,
	input  video_sync_t  sync,
	output raster_pos_t  pos,
	output raster_geom_t geom,
	output coord_t       hsize,
	output coord_t       vsize,
	output logic         vblank_end
);

	logic vblank;       // vblank or vs active
	logic hs_d;
	logic vs_d;
	logic hblank_d;
	logic vblank_d;
	logic hblank_rise;
	logic hblank_fall;
	logic vblank_rise;
	logic vblank_fall;
	logic hs_fall;
	logic vs_fall;

	assign vblank = sync.vblank | ~sync.vs;

	assign hblank_rise = ~hblank_d & sync.hblank;
	assign hblank_fall = hblank_d & ~sync.hblank;
	assign vblank_rise = ~vblank_d & vblank;
	assign vblank_fall = vblank_d & ~vblank;
	assign hs_fall     = hs_d & ~sync.hs;
	assign vs_fall     = vs_d & ~sync.vs;

	assign vblank_end = vblank_fall; // start of picture

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hs_d     <= 1'b1;
			vs_d     <= 1'b1;
			hblank_d <= 1'b0;
			vblank_d <= 1'b0;
		end else begin
			hs_d     <= sync.hs;
			vs_d     <= sync.vs;
			hblank_d <= sync.hblank;
			vblank_d <= vblank;
		end
	end

	// pixel and line counters
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			pos <= '0;
		end else begin
			pos.hcnt <= pos.hcnt + 12'd1;
			if (~sync.hs)
				pos.hcnt <= '0; // held through sync

			if (hs_fall)
				pos.vcnt <= pos.vcnt + 12'd1;
			if (~sync.vs)
				pos.vcnt <= '0;
		end
	end

	// edge captures
	always_ff @(posedge clk_sys) begin
		if (hblank_fall)
			geom.hend <= pos.hcnt;
		if (hblank_rise)
			geom.hsta <= pos.hcnt;
		if (hs_fall)
			geom.hmax <= pos.hcnt;

		if (vblank_fall)
			geom.vend <= pos.vcnt;
		if (vblank_rise)
			geom.vsta <= pos.vcnt;
		if (vs_fall)
			geom.vmax <= pos.vcnt;
	end

	// visible width on the first line after the last vblank start, height at vblank start
	always_ff @(posedge clk_sys) begin
		if (hblank_rise && pos.vcnt == geom.vsta + 12'd1)
			hsize <= pos.hcnt - geom.hend;
		if (vblank_rise)
			vsize <= pos.vcnt - geom.vend; // single field count
	end

endmodule

`default_nettype wire

// ==== hw/video_crop_pkg.sv ====
// shared types for the crop block; all coordinates are 12 bit and wrap, hs and vs active low
`default_nettype none

package video_crop_pkg;

	typedef logic [11:0] coord_t; // raster coordinate or size

	typedef struct packed {
		logic hs;     // active low
		logic vs;     // active low
		logic hblank; // active high
		logic vblank; // active high
	} video_sync_t;

	typedef struct packed {
		coord_t hcnt;
		coord_t vcnt;
	} raster_pos_t;

	typedef struct packed {
		coord_t hsta; // hblank rise, current line
		coord_t hend; // hblank fall
		coord_t hmax; // hs fall
		coord_t vsta; // vblank rise, current frame
		coord_t vend; // vblank fall
		coord_t vmax; // vs fall
	} raster_geom_t;

	typedef struct packed {
		coord_t hbl_l; // pixels
		coord_t hbl_r;
		coord_t vbl_t; // lines
		coord_t vbl_b;
	} crop_margins_t;

	typedef struct packed {
		logic       level; // toggles per event
		logic [1:0] kind;
		logic [7:0] code;
	} kbd_event_t;

	typedef struct packed {
		crop_margins_t margins;
		coord_t        hsize;
		coord_t        vsize;
		logic [1:0]    res;
		logic [6:0]    flg; // change counter, wraps at 128
	} screen_info_t;

	localparam logic [1:0] KIND_KEY = 2'd3;

	localparam logic [7:0] KEY_RESET   = 8'h41; // backspace
	localparam logic [7:0] KEY_UP      = 8'h4c;
	localparam logic [7:0] KEY_DOWN    = 8'h4d;
	localparam logic [7:0] KEY_LEFT    = 8'h4f;
	localparam logic [7:0] KEY_RIGHT   = 8'h4e;
	localparam logic [7:0] KEY_ALT_DN0 = 8'h64; // left and right alt press
	localparam logic [7:0] KEY_ALT_DN1 = 8'h65;
	localparam logic [7:0] KEY_ALT_UP0 = 8'he4; // release codes
	localparam logic [7:0] KEY_ALT_UP1 = 8'he5;

	localparam coord_t H_STEP = 12'd4;
	localparam coord_t V_STEP = 12'd1;

	// compare ahead of the registered enables
	localparam coord_t H_PIPE = 12'd2;
	localparam coord_t V_PIPE = 12'd1;

	localparam coord_t H_FORCE     = 12'd8;
	localparam coord_t V_FORCE_TOP = 12'd1;
	localparam coord_t V_FORCE_BOT = 12'd3;

endpackage

`default_nettype wire
